// File: include/halftone_cfg.svh
`ifndef HALFTONE_CFG_SVH
`define HALFTONE_CFG_SVH

// Image geometry
`define HT_COLS 8
`define HT_ROWS 6

// Width of a grey pixel and of a stored error
`define HT_PIXEL_W 8

// Number of lanes and step offset between adjacent rows
`define HT_LANES 4
`define HT_ROW_LAG 2

// Error weights normalised by the shift below
`define HT_W_LEFT 2
`define HT_W_UP_LEFT 8
`define HT_W_UP 4
`define HT_W_UP_RIGHT 2
`define HT_WEIGHT_SHIFT 4

`define HT_THRESHOLD 128
`define HT_CPV_W 10

`endif

// File: rtl/halftone_pkg.sv
`default_nettype none

`include "halftone_cfg.svh"

package halftone_pkg;

  typedef logic [`HT_PIXEL_W-1:0] pixel_t;
  typedef logic [`HT_PIXEL_W-1:0] err_t;

  // Rows and columns count from 1
  typedef logic [2:0] row_idx_t;
  typedef logic [3:0] col_idx_t;

  // Step 0 is idle, steps 1..HT_STEPS are the wavefront
  typedef logic [4:0] step_t;

  localparam int HT_STEPS = `HT_COLS + `HT_ROW_LAG * (`HT_ROWS - 1);

  typedef struct packed {
    logic     valid;
    row_idx_t row;
    col_idx_t col;
  } lane_cmd_t;

  typedef lane_cmd_t [`HT_LANES-1:0] lane_cmd_vec_t;

  typedef struct packed {
    pixel_t pixel;
    err_t   left;
    err_t   up_left;
    err_t   up;
    err_t   up_right;
  } neighbors_t;

  typedef struct packed {
    err_t err;
    logic ht;
  } lane_result_t;

  // Indexed [row-1][col-1]
  typedef pixel_t [`HT_ROWS-1:0][`HT_COLS-1:0] pixel_image_t;
  typedef logic [`HT_ROWS-1:0][`HT_COLS-1:0] halftone_image_t;

endpackage

`default_nettype wire

// File: rtl/diffusion_control.sv
`default_nettype none

`include "halftone_cfg.svh"

module diffusion_control (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        go,
  output logic                        load_image,
  output logic                        write_values,
  output logic                        done,
  output halftone_pkg::lane_cmd_vec_t lane_cmds
);
  import halftone_pkg::*;

  step_t step_q;
  step_t step_d;
  logic  idle;

  assign idle = (step_q == '0);

  // Go is only taken while idle
  assign load_image   = idle && go;
  assign write_values = !idle;
  assign done         = idle;

  always_comb begin
    step_d = step_q;
    if (idle) begin
      if (go) begin
        step_d = step_t'(1);
      end
    end else if (step_q == step_t'(HT_STEPS)) begin
      step_d = '0;
    end else begin
      step_d = step_q + step_t'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      step_q <= '0;
    end else begin
      step_q <= step_d;
    end
  end

  // Row r sits on column s - lag*(r-1) at step s
  // Rows sharing a lane are at least lanes*lag steps apart, so they never overlap
  always_comb begin : cmd_decode
    int col;
    int lane;
    lane_cmds = '0;
    for (int r = 1; r <= `HT_ROWS; r++) begin
      col  = int'(step_q) - `HT_ROW_LAG * (r - 1);
      lane = (r - 1) % `HT_LANES;
      if (!idle && col >= 1 && col <= `HT_COLS) begin
        lane_cmds[lane].valid = 1'b1;
        lane_cmds[lane].row   = row_idx_t'(r);
        lane_cmds[lane].col   = col_idx_t'(col);
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/image_store.sv
`default_nettype none

`include "halftone_cfg.svh"

module image_store (
  input  logic                                       clk,
  input  logic                                       reset,
  input  logic                                       load_image,
  input  logic                                       write_values,
  input  halftone_pkg::pixel_image_t                 pixels,
  input  halftone_pkg::lane_cmd_vec_t                lane_cmds,
  input  halftone_pkg::lane_result_t [`HT_LANES-1:0] lane_results,
  output halftone_pkg::neighbors_t   [`HT_LANES-1:0] lane_inputs,
  output halftone_pkg::halftone_image_t              halftone
);
  import halftone_pkg::*;

  pixel_image_t pix_q;

  // Row 0 and columns 0 and COLS+1 are the zero border
  err_t err_q [0:`HT_ROWS][0:`HT_COLS+1];

  // Neighbour fetch for every lane with a valid command
  always_comb begin : fetch
    int r;
    int c;
    lane_inputs = '0;
    for (int l = 0; l < `HT_LANES; l++) begin
      r = int'(lane_cmds[l].row);
      c = int'(lane_cmds[l].col);
      if (lane_cmds[l].valid) begin
        lane_inputs[l].pixel    = pix_q[r-1][c-1];
        lane_inputs[l].left     = err_q[r][c-1];
        lane_inputs[l].up_left  = err_q[r-1][c-1];
        lane_inputs[l].up       = err_q[r-1][c];
        lane_inputs[l].up_right = err_q[r-1][c+1];
      end
    end
  end

  // Load captures the image and zeroes every error including the border
  always_ff @(posedge clk) begin : err_write
    int r;
    int c;
    if (load_image) begin
      pix_q <= pixels;
      for (int i = 0; i <= `HT_ROWS; i++) begin
        for (int j = 0; j <= `HT_COLS + 1; j++) begin
          err_q[i][j] <= '0;
        end
      end
    end else if (write_values) begin
      for (int l = 0; l < `HT_LANES; l++) begin
        r = int'(lane_cmds[l].row);
        c = int'(lane_cmds[l].col);
        if (lane_cmds[l].valid) begin
          err_q[r][c] <= lane_results[l].err;
        end
      end
    end
  end

  // Written on the edge that ends the step so the next step reads it
  always_ff @(posedge clk) begin : ht_write
    int r;
    int c;
    if (reset) begin
      halftone <= '0;
    end else if (load_image) begin
      halftone <= '0;
    end else if (write_values) begin
      for (int l = 0; l < `HT_LANES; l++) begin
        r = int'(lane_cmds[l].row);
        c = int'(lane_cmds[l].col);
        if (lane_cmds[l].valid) begin
          halftone[r-1][c-1] <= lane_results[l].ht;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/diffusion_pe.sv
`default_nettype none

`include "halftone_cfg.svh"

module diffusion_pe (
  input  halftone_pkg::neighbors_t   operands,
  output halftone_pkg::lane_result_t result
);

  // Sum of four 8-bit errors with weights totalling 16 fits in 12 bits
  localparam int PIXEL_W = `HT_PIXEL_W;
  localparam int SUM_W   = `HT_PIXEL_W + `HT_WEIGHT_SHIFT;
  localparam int CPV_W   = `HT_CPV_W;
  localparam int FULL    = (1 << `HT_PIXEL_W) - 1;

  logic [SUM_W-1:0]   weighted_sum;
  logic [PIXEL_W-1:0] e_av;
  logic [CPV_W-1:0]   cpv;
  logic [CPV_W-1:0]   residual;
  logic               ht;

  assign weighted_sum = SUM_W'(`HT_W_LEFT)     * SUM_W'(operands.left)
                      + SUM_W'(`HT_W_UP_LEFT)  * SUM_W'(operands.up_left)
                      + SUM_W'(`HT_W_UP)       * SUM_W'(operands.up)
                      + SUM_W'(`HT_W_UP_RIGHT) * SUM_W'(operands.up_right);

  assign e_av = PIXEL_W'(weighted_sum >> `HT_WEIGHT_SHIFT);

  assign cpv = CPV_W'(operands.pixel) + CPV_W'(e_av);

  assign ht = (cpv >= CPV_W'(`HT_THRESHOLD));

  // Residual wraps modulo 256 when kept in the error store
  assign residual = cpv - (ht ? CPV_W'(FULL) : CPV_W'(0));

  assign result.err = residual[PIXEL_W-1:0];
  assign result.ht  = ht;

endmodule

`default_nettype wire

// File: rtl/halftone_top.sv
`default_nettype none

`include "halftone_cfg.svh"

module halftone_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          go,
  input  halftone_pkg::pixel_image_t    pixels,
  output halftone_pkg::halftone_image_t halftone,
  output logic                          done
);
  import halftone_pkg::*;

  logic          load_image;
  logic          write_values;
  lane_cmd_vec_t lane_cmds;

  neighbors_t   [`HT_LANES-1:0] lane_inputs;
  lane_result_t [`HT_LANES-1:0] lane_results;

  diffusion_control u_control (
    .clk          (clk),
    .reset        (reset),
    .go           (go),
    .load_image   (load_image),
    .write_values (write_values),
    .done         (done),
    .lane_cmds    (lane_cmds)
  );

  image_store u_store (
    .clk          (clk),
    .reset        (reset),
    .load_image   (load_image),
    .write_values (write_values),
    .pixels       (pixels),
    .lane_cmds    (lane_cmds),
    .lane_results (lane_results),
    .lane_inputs  (lane_inputs),
    .halftone     (halftone)
  );

  // One lane per row slot of the wavefront
  genvar g;
  for (g = 0; g < `HT_LANES; g++) begin : g_lane
    diffusion_pe u_pe (
      .operands (lane_inputs[g]),
      .result   (lane_results[g])
    );
  end

endmodule

`default_nettype wire

// File: verif/halftone_properties.sv
`default_nettype none

module halftone_properties (
  input logic clk,
  input logic reset,
  input logic go,
  input logic done
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RUN_STEPS = 18;

  // Failed assertions so far
  int failures = 0;

  // A go taken while idle starts a run on the same edge
  start_on_go: assert property (@(posedge clk) disable iff (reset)
    (go && done) |=> !done)
    else begin
      $error("go while idle did not drop done");
      failures++;
    end

  // Once done falls it stays low for one cycle per wavefront step
  run_length: assert property (@(posedge clk) disable iff (reset)
    $fell(done) |-> (!done) [*RUN_STEPS] ##1 done)
    else begin
      $error("done was not low for exactly %0d cycles", RUN_STEPS);
      failures++;
    end

  idle_after_reset: assert property (@(posedge clk) $fell(reset) |-> done)
    else begin
      $error("done was not high after reset release");
      failures++;
    end

endmodule

bind halftone_top halftone_properties u_props (
  .clk   (clk),
  .reset (reset),
  .go    (go),
  .done  (done)
);

`default_nettype wire

// File: verif/halftone_tb.sv
`default_nettype none

module halftone_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import halftone_pkg::*;

  localparam int ROWS = 6;
  localparam int COLS = 8;
  localparam int RUN_STEPS = 18;
  localparam int RESET_CYCLES = 10;
  localparam int RANDOM_IMAGES = 20;
  // Timing 1, random 20, extremes 3, back-to-back 2
  localparam int RUNS = 26;
  localparam int RUN_GAP = 4;
  localparam int TIMEOUT_CYCLES = 2 * RUNS * (RUN_STEPS + RUN_GAP) + RESET_CYCLES;
  localparam logic [31:0] SEED = 32'hb664829e;

  logic            clk;
  logic            reset;
  logic            go;
  pixel_image_t    pixels;
  halftone_image_t halftone;
  logic            done;

  logic [31:0] lfsr_state;
  int          test_errors;
  int          total_errors;
  int          tests_run;
  int          tests_failed;
  int          cycle_count;

  halftone_top dut (
    .clk      (clk),
    .reset    (reset),
    .go       (go),
    .pixels   (pixels),
    .halftone (halftone),
    .done     (done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, done never came back", cycle_count);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits[i] = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic random_image(output pixel_image_t img);
    logic [31:0] bits;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        take_bits(8, bits);
        img[r][c] = bits[7:0];
      end
    end
  endtask

  task automatic fill_image(input logic [7:0] value, output pixel_image_t img);
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        img[r][c] = value;
      end
    end
  endtask

  // Raster order error diffusion with a zero border around the error array
  function automatic halftone_image_t model_halftone(input pixel_image_t img);
    int err [0:ROWS][0:COLS+1];
    int sum;
    int cpv;
    halftone_image_t ht;
    ht = '0;
    for (int i = 0; i <= ROWS; i++) begin
      for (int j = 0; j <= COLS + 1; j++) begin
        err[i][j] = 0;
      end
    end
    for (int r = 1; r <= ROWS; r++) begin
      for (int c = 1; c <= COLS; c++) begin
        sum = 2 * err[r][c-1] + 8 * err[r-1][c-1] + 4 * err[r-1][c] + 2 * err[r-1][c+1];
        cpv = int'(img[r-1][c-1]) + (sum >> 4);
        ht[r-1][c-1] = (cpv >= 128);
        err[r][c] = (cpv - ((cpv >= 128) ? 255 : 0)) & 255;
      end
    end
    return ht;
  endfunction

  task automatic check_int(input string name, input int expected, input int actual);
    assert (actual == expected)
      else begin
        $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
        test_errors++;
      end
  endtask

  task automatic check_image(input string name, input halftone_image_t expected);
    assert (halftone === expected)
      else begin
        $display("MISMATCH %s: expected %h, actual %h", name, expected, halftone);
        test_errors++;
      end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, test_errors);
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  // Go is sampled on the second edge, which is the load edge
  task automatic start_run(input pixel_image_t img);
    @(posedge clk);
    pixels <= img;
    go     <= 1'b1;
    @(posedge clk);
    go     <= 1'b0;
  endtask

  task automatic wait_done(output int low_cycles);
    low_cycles = 0;
    @(negedge clk);
    while (!done) begin
      low_cycles++;
      @(negedge clk);
    end
  endtask

  task automatic run_and_check(input string name, input pixel_image_t img);
    int low_cycles;
    start_run(img);
    wait_done(low_cycles);
    check_int({name, " done low cycles"}, RUN_STEPS, low_cycles);
    check_image(name, model_halftone(img));
  endtask

  initial begin
    pixel_image_t img_a;
    pixel_image_t img_b;
    int           low_cycles;
    reset        = 1'b1;
    go           = 1'b0;
    pixels       = '0;
    lfsr_state   = SEED;
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;

    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_int("reset done", 1, int'(done));
    check_image("reset halftone", '0);
    finish_test("reset");

    // Second go and new pixels arrive mid-run and must be ignored
    random_image(img_a);
    random_image(img_b);
    start_run(img_a);
    fork
      wait_done(low_cycles);
      begin
        repeat (5) @(posedge clk);
        go     <= 1'b1;
        pixels <= img_b;
        @(posedge clk);
        go     <= 1'b0;
      end
    join
    check_int("timing done low cycles", RUN_STEPS, low_cycles);
    check_image("timing result", model_halftone(img_a));
    finish_test("timing");

    for (int i = 0; i < RANDOM_IMAGES; i++) begin
      random_image(img_a);
      run_and_check($sformatf("random image %0d", i), img_a);
    end
    finish_test("random images");

    fill_image(8'd0, img_a);
    run_and_check("all 0", img_a);
    check_image("all 0 cleared", '0);
    fill_image(8'd255, img_a);
    run_and_check("all 255", img_a);
    check_image("all 255 set", '1);
    fill_image(8'd128, img_a);
    run_and_check("uniform 128", img_a);
    finish_test("extremes");

    // Go for the second image is held from mid-run so the first idle edge loads it
    random_image(img_a);
    random_image(img_b);
    start_run(img_a);
    fork
      wait_done(low_cycles);
      begin
        @(posedge clk);
        go     <= 1'b1;
        pixels <= img_b;
      end
    join
    check_int("back-to-back first done low cycles", RUN_STEPS, low_cycles);
    check_image("back-to-back first", model_halftone(img_a));
    @(posedge clk);
    go <= 1'b0;
    wait_done(low_cycles);
    check_int("back-to-back second done low cycles", RUN_STEPS, low_cycles);
    check_image("back-to-back second", model_halftone(img_b));
    finish_test("back-to-back");

    $display("tests run %0d, tests failed %0d, check errors %0d, property failures %0d",
             tests_run, tests_failed, total_errors, dut.u_props.failures);
    if (total_errors == 0 && dut.u_props.failures == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
rtl/halftone_pkg.sv
rtl/diffusion_control.sv
rtl/image_store.sv
rtl/diffusion_pe.sv
rtl/halftone_top.sv
verif/halftone_properties.sv
verif/halftone_tb.sv
